// ==== hdl/ahb_pkg.sv ====
// AHB protocol definitions shared by the master multiplexer and its testbench.
// Holds the bus widths and the transfer-type encoding. Modules take it by a
// wildcard import in their header.

package ahb_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SIZE_W = 3;

  // HTRANS encodings as defined by AHB
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

endpackage

// ==== hdl/master_mux_pkg.sv ====
// Definitions of the three-to-one master multiplexer itself.
// Gives the port count, the high-priority port and the HMASTER encoding
// that tells which master owns the current address phase.

package master_mux_pkg;

  // Number of master ports and the one with fixed high priority
  localparam int NUM_PORTS = 3;
  localparam int PRIO_PORT = 2;

  // Address-phase owner as seen on HMASTERM
  typedef enum logic [1:0] {
    MST_PORT0 = 2'd0,
    MST_PORT1 = 2'd1,
    MST_PORT2 = 2'd2,
    MST_NONE  = 2'd3
  } hmaster_t;

endpackage

// ==== hdl/ahb_input_stage.sv ====
`timescale 1ns/1ps
// Input stage of one master port.
// Captures an address phase that arrives while the port is not granted and
// replays it to the output multiplexer once the arbiter selects the port.
// Also routes the slave response back to this master while it owns the
// data phase, and stalls the master while a request is held.

module ahb_input_stage
  import ahb_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              hsel,
  input  logic [ADDR_W-1:0] haddr,
  input  htrans_t           htrans,
  input  logic [SIZE_W-1:0] hsize,
  input  logic              hwrite,
  input  logic              hready,
  input  logic              grant_addr,
  input  logic              grant_data,
  input  logic              hreadyout_m,
  input  logic              hresp_m,
  output logic              req,
  output logic              ips_hsel,
  output logic [ADDR_W-1:0] ips_haddr,
  output htrans_t           ips_htrans,
  output logic [SIZE_W-1:0] ips_hsize,
  output logic              ips_hwrite,
  output logic              ips_hready,
  output logic              hreadyout,
  output logic              hresp
);

  logic              trans_valid;
  logic              accepted;
  logic              input_hold;
  logic              hold_active;
  logic [ADDR_W-1:0] haddr_q;
  logic              seq_q;     // HTRANS[1] is always set for a held phase
  logic [SIZE_W-1:0] hsize_q;
  logic              hwrite_q;

  // NONSEQ or SEQ with the master ready
  assign trans_valid = hsel & htrans[1] & hready;
  assign accepted    = grant_addr & hreadyout_m;
  assign input_hold  = trans_valid & ~accepted;
  assign req         = trans_valid | hold_active;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      hold_active <= 1'b0;
    else
      hold_active <= input_hold | (hold_active & ~accepted);
  end

  always_ff @(posedge HCLK)
  begin
    if (input_hold)
    begin
      haddr_q  <= haddr;
      seq_q    <= htrans[0];
      hsize_q  <= hsize;
      hwrite_q <= hwrite;
    end
  end

  // Held copy takes over until the port is granted
  assign ips_hsel   = hold_active | hsel;
  assign ips_haddr  = hold_active ? haddr_q : haddr;
  assign ips_htrans = hold_active ? htrans_t'({1'b1, seq_q}) : htrans;
  assign ips_hsize  = hold_active ? hsize_q : hsize;
  assign ips_hwrite = hold_active ? hwrite_q : hwrite;
  assign ips_hready = hold_active | hready;

  // Wait while holding, otherwise pass the slave response if data phase owner
  assign hreadyout = ~hold_active & (grant_data ? hreadyout_m : 1'b1);
  assign hresp     = grant_data & hresp_m;

endmodule

// ==== hdl/ahb_arbiter.sv ====
`timescale 1ns/1ps
// Arbiter of the three-to-one master multiplexer.
// Port 2 has fixed high priority, ports 0 and 1 share the bus by round
// robin. The grant is combinational and is frozen for one cycle after an
// announced transfer was stalled. Also keeps the data-phase owner and the
// flag for a data phase that carries a real transfer.

module ahb_arbiter
  import ahb_pkg::*, master_mux_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic [NUM_PORTS-1:0] req,
  input  logic                 hsel_m,
  input  htrans_t              htrans_m,
  input  logic                 hready_mux,
  output logic [NUM_PORTS-1:0] sel_addr,
  output logic [NUM_PORTS-1:0] sel_data,
  output logic                 active_transfer
);

  logic                 announced;
  logic                 stall_q;
  logic [NUM_PORTS-1:0] last_grant_q;
  logic                 rr_q;   // Set when port 1 had the last shared grant

  assign announced = hsel_m & htrans_m[1];

  // --------------------------------------------------------------------------
  // Stall hold tracked every cycle
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      stall_q      <= 1'b0;
      last_grant_q <= '0;
    end
    else
    begin
      stall_q      <= announced & ~hready_mux;
      last_grant_q <= sel_addr;
    end
  end

  // --------------------------------------------------------------------------
  // Grant selection
  // --------------------------------------------------------------------------
  always_comb
  begin
    sel_addr = '0;
    if (stall_q)
      sel_addr = last_grant_q;
    else if (req[PRIO_PORT])
      sel_addr[PRIO_PORT] = 1'b1;
    else if (req[0] && req[1])
    begin
      // Port 0 follows port 1 and the other way round
      sel_addr[0] = rr_q;
      sel_addr[1] = ~rr_q;
    end
    else
      sel_addr = req;
  end

  // Data-phase registers advance with the accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      rr_q            <= 1'b1;  // first contention goes to port 0
      sel_data        <= '0;
      active_transfer <= 1'b0;
    end
    else if (hready_mux)
    begin
      rr_q            <= sel_addr[1] | (rr_q & ~sel_addr[0]);
      sel_data        <= sel_addr;
      active_transfer <= announced;
    end
  end

endmodule

// ==== hdl/ahb_bus_mux.sv ====
`timescale 1ns/1ps
// Output multiplexer of the three-to-one master multiplexer.
// Steers the address phase by the address-phase grant and the write data
// by the data-phase owner, merges HREADY, turns SEQ into NONSEQ when the
// master changed or the bus was idle, and encodes HMASTER.

module ahb_bus_mux
  import ahb_pkg::*, master_mux_pkg::*;
(
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [NUM_PORTS-1:0]             ips_hsel,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0] ips_haddr,
  input  htrans_t [NUM_PORTS-1:0]          ips_htrans,
  input  logic [NUM_PORTS-1:0][SIZE_W-1:0] ips_hsize,
  input  logic [NUM_PORTS-1:0]             ips_hwrite,
  input  logic [NUM_PORTS-1:0]             ips_hready,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] hwdata,
  input  logic [NUM_PORTS-1:0]             sel_addr,
  input  logic [NUM_PORTS-1:0]             sel_data,
  input  logic                             active_transfer,
  input  logic                             hreadyout_m,
  output logic                             hsel_m,
  output logic [ADDR_W-1:0]                haddr_m,
  output htrans_t                          htrans_m,
  output logic [SIZE_W-1:0]                hsize_m,
  output logic                             hwrite_m,
  output logic                             hready_mux,
  output logic [DATA_W-1:0]                hwdata_m,
  output hmaster_t                         hmaster_m
);

  logic [1:0] trans_mux;
  logic       idle_q;
  logic       seq_suppress;

  // AND-OR multiplexers on one-hot selects
  always_comb
  begin
    hsel_m    = 1'b0;
    haddr_m   = '0;
    trans_mux = 2'b00;
    hsize_m   = '0;
    hwrite_m  = 1'b0;
    hwdata_m  = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      hsel_m    = hsel_m | (sel_addr[i] & ips_hsel[i]);
      haddr_m   = haddr_m | ({ADDR_W{sel_addr[i]}} & ips_haddr[i]);
      trans_mux = trans_mux | ({2{sel_addr[i]}} & ips_htrans[i]);
      hsize_m   = hsize_m | ({SIZE_W{sel_addr[i]}} & ips_hsize[i]);
      hwrite_m  = hwrite_m | (sel_addr[i] & ips_hwrite[i]);
      hwdata_m  = hwdata_m | ({DATA_W{sel_data[i]}} & hwdata[i]);
    end
  end

  // Slave ready during a real data phase, else the granted master's HREADY
  assign hready_mux = active_transfer ? hreadyout_m
                                      : (|(sel_addr & ips_hready)) | ~(|sel_addr);

  // Remembers an IDLE address phase that is still waiting on the slave
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      idle_q <= 1'b0;
    else
      idle_q <= ((htrans_m == IDLE) | idle_q) & ~hreadyout_m;
  end

  // ---------------------------------------------------------------------------
  // SEQ is only legal when the same master continues
  // ---------------------------------------------------------------------------
  assign seq_suppress = (sel_addr != sel_data) | idle_q;
  assign htrans_m     = htrans_t'({trans_mux[1], trans_mux[0] & ~seq_suppress});

  always_comb
  begin
    case (sel_addr)
      3'b001:  hmaster_m = MST_PORT0;
      3'b010:  hmaster_m = MST_PORT1;
      3'b100:  hmaster_m = MST_PORT2;
      default: hmaster_m = MST_NONE;
    endcase
  end

endmodule

// ==== hdl/ahb_master_mux.sv ====
`timescale 1ns/1ps
// Top level of the three-to-one AHB master multiplexer.
// Three masters share one AHB slave port. Each master has its own input
// stage, one arbiter picks the address-phase owner and the bus multiplexer
// drives the slave side. HMASTERM shows the current address-phase owner.

module ahb_master_mux
  import ahb_pkg::*, master_mux_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  // Master port 0
  input  logic              HSELS0,
  input  logic [ADDR_W-1:0] HADDRS0,
  input  htrans_t           HTRANSS0,
  input  logic [SIZE_W-1:0] HSIZES0,
  input  logic              HWRITES0,
  input  logic              HREADYS0,
  input  logic [DATA_W-1:0] HWDATAS0,
  output logic              HREADYOUTS0,
  output logic              HRESPS0,
  output logic [DATA_W-1:0] HRDATAS0,
  // Master port 1
  input  logic              HSELS1,
  input  logic [ADDR_W-1:0] HADDRS1,
  input  htrans_t           HTRANSS1,
  input  logic [SIZE_W-1:0] HSIZES1,
  input  logic              HWRITES1,
  input  logic              HREADYS1,
  input  logic [DATA_W-1:0] HWDATAS1,
  output logic              HREADYOUTS1,
  output logic              HRESPS1,
  output logic [DATA_W-1:0] HRDATAS1,
  // Master port 2 with high priority
  input  logic              HSELS2,
  input  logic [ADDR_W-1:0] HADDRS2,
  input  htrans_t           HTRANSS2,
  input  logic [SIZE_W-1:0] HSIZES2,
  input  logic              HWRITES2,
  input  logic              HREADYS2,
  input  logic [DATA_W-1:0] HWDATAS2,
  output logic              HREADYOUTS2,
  output logic              HRESPS2,
  output logic [DATA_W-1:0] HRDATAS2,
  // Slave side
  output logic              HSELM,
  output logic [ADDR_W-1:0] HADDRM,
  output htrans_t           HTRANSM,
  output logic [SIZE_W-1:0] HSIZEM,
  output logic              HWRITEM,
  output logic              HREADYM,
  output logic [DATA_W-1:0] HWDATAM,
  output hmaster_t          HMASTERM,
  input  logic              HREADYOUTM,
  input  logic              HRESPM,
  input  logic [DATA_W-1:0] HRDATAM
);

  logic [NUM_PORTS-1:0]             req;
  logic [NUM_PORTS-1:0]             sel_addr;
  logic [NUM_PORTS-1:0]             sel_data;
  logic                             active_transfer;
  logic                             hready_mux;
  logic [NUM_PORTS-1:0]             ips_hsel;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] ips_haddr;
  htrans_t [NUM_PORTS-1:0]          ips_htrans;
  logic [NUM_PORTS-1:0][SIZE_W-1:0] ips_hsize;
  logic [NUM_PORTS-1:0]             ips_hwrite;
  logic [NUM_PORTS-1:0]             ips_hready;
  logic [NUM_PORTS-1:0][DATA_W-1:0] hwdata;

  assign hwdata   = {HWDATAS2, HWDATAS1, HWDATAS0};
  assign HREADYM  = hready_mux;
  // Read data goes to every master unchanged
  assign HRDATAS0 = HRDATAM;
  assign HRDATAS1 = HRDATAM;
  assign HRDATAS2 = HRDATAM;

  // ---------------------------------------------------------------------------
  // Input stages
  // ---------------------------------------------------------------------------
  ahb_input_stage u_stage0 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(HSELS0), .haddr(HADDRS0), .htrans(HTRANSS0),
    .hsize(HSIZES0), .hwrite(HWRITES0), .hready(HREADYS0),
    .grant_addr(sel_addr[0]), .grant_data(sel_data[0]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM), .req(req[0]),
    .ips_hsel(ips_hsel[0]), .ips_haddr(ips_haddr[0]), .ips_htrans(ips_htrans[0]),
    .ips_hsize(ips_hsize[0]), .ips_hwrite(ips_hwrite[0]), .ips_hready(ips_hready[0]),
    .hreadyout(HREADYOUTS0), .hresp(HRESPS0)
  );

  ahb_input_stage u_stage1 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(HSELS1), .haddr(HADDRS1), .htrans(HTRANSS1),
    .hsize(HSIZES1), .hwrite(HWRITES1), .hready(HREADYS1),
    .grant_addr(sel_addr[1]), .grant_data(sel_data[1]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM), .req(req[1]),
    .ips_hsel(ips_hsel[1]), .ips_haddr(ips_haddr[1]), .ips_htrans(ips_htrans[1]),
    .ips_hsize(ips_hsize[1]), .ips_hwrite(ips_hwrite[1]), .ips_hready(ips_hready[1]),
    .hreadyout(HREADYOUTS1), .hresp(HRESPS1)
  );

  ahb_input_stage u_stage2 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(HSELS2), .haddr(HADDRS2), .htrans(HTRANSS2),
    .hsize(HSIZES2), .hwrite(HWRITES2), .hready(HREADYS2),
    .grant_addr(sel_addr[2]), .grant_data(sel_data[2]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM), .req(req[2]),
    .ips_hsel(ips_hsel[2]), .ips_haddr(ips_haddr[2]), .ips_htrans(ips_htrans[2]),
    .ips_hsize(ips_hsize[2]), .ips_hwrite(ips_hwrite[2]), .ips_hready(ips_hready[2]),
    .hreadyout(HREADYOUTS2), .hresp(HRESPS2)
  );

  // Arbiter sees the slave-side address phase after SEQ suppression
  ahb_arbiter u_arbiter (
    .HCLK(HCLK), .HRESETn(HRESETn), .req(req),
    .hsel_m(HSELM), .htrans_m(HTRANSM), .hready_mux(hready_mux),
    .sel_addr(sel_addr), .sel_data(sel_data), .active_transfer(active_transfer)
  );

  ahb_bus_mux u_bus_mux (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .ips_hsel(ips_hsel), .ips_haddr(ips_haddr), .ips_htrans(ips_htrans),
    .ips_hsize(ips_hsize), .ips_hwrite(ips_hwrite), .ips_hready(ips_hready),
    .hwdata(hwdata), .sel_addr(sel_addr), .sel_data(sel_data),
    .active_transfer(active_transfer), .hreadyout_m(HREADYOUTM),
    .hsel_m(HSELM), .haddr_m(HADDRM), .htrans_m(HTRANSM),
    .hsize_m(HSIZEM), .hwrite_m(HWRITEM), .hready_mux(hready_mux),
    .hwdata_m(HWDATAM), .hmaster_m(HMASTERM)
  );

endmodule

// ==== testbench/tb_ahb_master_mux.sv ====
`timescale 1ns/1ps
// Testbench of the three-to-one AHB master multiplexer.
// Applies a table of request patterns, models three simple masters and one
// slave with wait states and errors, and checks grant order, address and
// data routing, responses and read-data fan-out against the expected values.

module tb_ahb_master_mux
  import ahb_pkg::*, master_mux_pkg::*;
  ;

  typedef struct packed {
    logic [2:0] mask;    // ports that request in this row
    logic [2:0] seq;     // 1 drives SEQ, 0 drives NONSEQ
    logic [2:0] write;
    logic [3:0] waits;
    logic       err;
    logic [1:0] ngrant;
    logic [5:0] order;   // expected HMASTERM values with the first grant in [1:0]
  } row_t;

  localparam int NUM_ROWS = 10;

  logic HCLK = 1'b0;
  logic HRESETn;
  logic [2:0] hsel, hwrite, hready_s, hreadyout, hresp;
  logic [2:0][31:0] haddr, hwdata;
  logic [2:0] hsize_s;
  htrans_t htrans [3];
  logic [31:0] hrdata [3];
  logic hsel_m, hwrite_m, hready_m, hreadyout_m, hresp_m;
  logic [31:0] haddr_m, hwdata_m, hrdata_m;
  logic [2:0] hsize_m;
  htrans_t htrans_m;
  hmaster_t hmaster_m;

  // Master and slave model state
  row_t rows [NUM_ROWS];
  row_t cur;
  int mst_state [3];     // 0 idle, 1 address phase, 2 data phase
  logic [2:0] seen;      // address already reached the slave side
  logic [31:0] exp_addr [3];
  logic [31:0] exp_wdata [3];
  logic s_active, s_err_half, s_write;
  int s_owner, s_wait, grant_cnt;
  logic [31:0] lcg_state = 32'd85552;

  always #50 HCLK = ~HCLK;

  ahb_master_mux dut_i (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .HSELS0(hsel[0]), .HADDRS0(haddr[0]), .HTRANSS0(htrans[0]), .HSIZES0(hsize_s),
    .HWRITES0(hwrite[0]), .HREADYS0(hready_s[0]), .HWDATAS0(hwdata[0]),
    .HREADYOUTS0(hreadyout[0]), .HRESPS0(hresp[0]), .HRDATAS0(hrdata[0]),
    .HSELS1(hsel[1]), .HADDRS1(haddr[1]), .HTRANSS1(htrans[1]), .HSIZES1(hsize_s),
    .HWRITES1(hwrite[1]), .HREADYS1(hready_s[1]), .HWDATAS1(hwdata[1]),
    .HREADYOUTS1(hreadyout[1]), .HRESPS1(hresp[1]), .HRDATAS1(hrdata[1]),
    .HSELS2(hsel[2]), .HADDRS2(haddr[2]), .HTRANSS2(htrans[2]), .HSIZES2(hsize_s),
    .HWRITES2(hwrite[2]), .HREADYS2(hready_s[2]), .HWDATAS2(hwdata[2]),
    .HREADYOUTS2(hreadyout[2]), .HRESPS2(hresp[2]), .HRDATAS2(hrdata[2]),
    .HSELM(hsel_m), .HADDRM(haddr_m), .HTRANSM(htrans_m), .HSIZEM(hsize_m),
    .HWRITEM(hwrite_m), .HREADYM(hready_m), .HWDATAM(hwdata_m), .HMASTERM(hmaster_m),
    .HREADYOUTM(hreadyout_m), .HRESPM(hresp_m), .HRDATAM(hrdata_m)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_condition(bit ok, string what);
    assert (ok)
    else
    begin
      $display("Error: time %0t %s", $time, what);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------------------
  // Drive masters and slave response on the falling edge
  // ------------------------------------------------------------------------
  task automatic drive_inputs();
    for (int p = 0; p < 3; p++)
    begin
      hsel[p]   = (mst_state[p] == 1);
      htrans[p] = (mst_state[p] != 1) ? IDLE : (cur.seq[p] ? SEQ : NONSEQ);
      haddr[p]  = exp_addr[p];
      hwrite[p] = cur.write[p];
      hwdata[p] = exp_wdata[p];
    end
    hreadyout_m = 1'b1;
    hresp_m     = 1'b0;
    if (s_active && s_wait > 0)
    begin
      hreadyout_m = 1'b0;
      s_wait--;
    end
    else if (s_active && cur.err)
    begin
      // Two-cycle error response
      hreadyout_m = s_err_half;
      hresp_m     = 1'b1;
      s_err_half  = 1'b1;
    end
    hrdata_m = lcg_next();
  endtask

  // Sampled shortly before the rising edge, when everything is settled
  task automatic sample_and_check();
    int p;
    for (int i = 0; i < 3; i++)
    begin
      check_value($sformatf("HRDATAS%0d", i), hrdata[i], hrdata_m);
      if (mst_state[i] == 0)
      begin
        check_value($sformatf("HREADYOUTS%0d", i), hreadyout[i], 1);
        check_value($sformatf("HRESPS%0d", i), hresp[i], 0);
      end
      else if (mst_state[i] == 2 && !seen[i])
      begin
        check_value($sformatf("HREADYOUTS%0d", i), hreadyout[i], 0);
        check_value($sformatf("HRESPS%0d", i), hresp[i], 0);
      end
    end
    if (s_active)
    begin
      check_value($sformatf("HREADYOUTS%0d", s_owner), hreadyout[s_owner], hreadyout_m);
      check_value($sformatf("HRESPS%0d", s_owner), hresp[s_owner], hresp_m);
      if (hreadyout_m)
      begin
        if (s_write)
          check_value("HWDATAM", hwdata_m, exp_wdata[s_owner]);
        s_active = 1'b0;
      end
    end
    // New address phase accepted at the slave
    if (hsel_m && htrans_m[1] && hready_m)
    begin
      check_condition(grant_cnt < cur.ngrant,
                      "more address phases reached the slave than the row expects");
      check_value("HMASTERM", hmaster_m, cur.order[2*grant_cnt +: 2]);
      p = int'(hmaster_m);
      check_value("HADDRM", haddr_m, exp_addr[p]);
      check_value("HTRANSM", htrans_m, NONSEQ);
      check_value("HWRITEM", hwrite_m, cur.write[p]);
      check_value("HSIZEM", hsize_m, 3'b010);
      seen[p]    = 1'b1;
      s_active   = 1'b1;
      s_owner    = p;
      s_wait     = cur.waits;
      s_err_half = 1'b0;
      s_write    = cur.write[p];
      grant_cnt++;
    end
    for (int i = 0; i < 3; i++)
    begin
      if (mst_state[i] == 1)
      begin
        // A master sees ready high in its own address cycle
        check_value($sformatf("HREADYOUTS%0d", i), hreadyout[i], 1);
        // First grant of a row goes out with no added latency
        if (i == int'(cur.order[1:0]))
          check_condition(seen[i],
            $sformatf("port %0d address phase did not reach the slave at once", i));
        mst_state[i] = 2;
      end
      else if (mst_state[i] == 2 && seen[i] && hreadyout[i])
      begin
        check_value($sformatf("HRESPS%0d", i), hresp[i], cur.err);
        mst_state[i] = 0;
      end
    end
  endtask

  initial
  begin
    #(NUM_ROWS * 40 * 100);
    $display("Timeout: the transfers did not complete within the allowed time");
    $display("=== FAIL ===");
    $fatal(1);
  end

  initial
  begin
    //        mask    seq     write   waits err ngrant order
    rows[0] = '{3'b011, 3'b000, 3'b011, 4'd0, 1'b0, 2'd2, {MST_NONE, MST_PORT1, MST_PORT0}};
    rows[1] = '{3'b011, 3'b010, 3'b001, 4'd1, 1'b0, 2'd2, {MST_NONE, MST_PORT1, MST_PORT0}};
    rows[2] = '{3'b011, 3'b011, 3'b010, 4'd2, 1'b0, 2'd2, {MST_NONE, MST_PORT1, MST_PORT0}};
    rows[3] = '{3'b001, 3'b001, 3'b001, 4'd0, 1'b0, 2'd1, {MST_NONE, MST_NONE, MST_PORT0}};
    rows[4] = '{3'b010, 3'b000, 3'b000, 4'd1, 1'b0, 2'd1, {MST_NONE, MST_NONE, MST_PORT1}};
    rows[5] = '{3'b100, 3'b100, 3'b100, 4'd2, 1'b1, 2'd1, {MST_NONE, MST_NONE, MST_PORT2}};
    rows[6] = '{3'b101, 3'b000, 3'b101, 4'd1, 1'b0, 2'd2, {MST_NONE, MST_PORT0, MST_PORT2}};
    rows[7] = '{3'b110, 3'b110, 3'b010, 4'd0, 1'b1, 2'd2, {MST_NONE, MST_PORT1, MST_PORT2}};
    rows[8] = '{3'b111, 3'b000, 3'b111, 4'd1, 1'b0, 2'd3, {MST_PORT1, MST_PORT0, MST_PORT2}};
    rows[9] = '{3'b011, 3'b001, 3'b011, 4'd0, 1'b1, 2'd2, {MST_NONE, MST_PORT1, MST_PORT0}};
    cur = '0;
    for (int i = 0; i < 3; i++)
    begin
      mst_state[i] = 0;
      exp_addr[i]  = '0;
      exp_wdata[i] = '0;
      htrans[i]    = IDLE;
    end
    hsel = '0;
    hwrite = '0;
    hready_s = '1;
    haddr = '0;
    hwdata = '0;
    hsize_s = 3'b010;
    hreadyout_m = 1'b1;
    hresp_m = 1'b0;
    hrdata_m = '0;
    seen = '0;
    s_active = 1'b0;
    s_err_half = 1'b0;
    s_write = 1'b0;
    HRESETn = 1'b0;
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    #40;
    // Idle bus after reset
    check_value("HSELM", hsel_m, 0);
    check_value("HTRANSM", htrans_m, IDLE);
    check_value("HREADYM", hready_m, 1);
    check_value("HMASTERM", hmaster_m, MST_NONE);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      cur = rows[r];
      seen = '0;
      grant_cnt = 0;
      for (int i = 0; i < 3; i++)
      begin
        if (cur.mask[i])
        begin
          mst_state[i] = 1;
          exp_addr[i]  = lcg_next() & 32'hFFFF_FFFC;
          exp_wdata[i] = lcg_next();
        end
      end
      do
      begin
        @(negedge HCLK);
        drive_inputs();
        #40;
        sample_and_check();
      end
      while (s_active || mst_state[0] != 0 || mst_state[1] != 0 || mst_state[2] != 0);
      check_value("number of grants", grant_cnt, cur.ngrant);
      @(negedge HCLK);
      drive_inputs();
      #40;
      sample_and_check();
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== ahb_master_mux.f ====
hdl/ahb_pkg.sv
hdl/master_mux_pkg.sv
hdl/ahb_input_stage.sv
hdl/ahb_arbiter.sv
hdl/ahb_bus_mux.sv
hdl/ahb_master_mux.sv
testbench/tb_ahb_master_mux.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

out=$( { verilator --binary --timing -Wno-fatal --top-module tb_ahb_master_mux \
         -f ahb_master_mux.f -o sim && ./obj_dir/sim; } 2>&1 )
echo "$out"

echo "$out" | grep -qx "=== PASS ===" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
